/* source/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  localparam int XLEN       = 64;
  localparam int ILEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  localparam logic [XLEN-1:0] REG_INIT = 64'h0;

  // Major opcodes kept in this subset
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB and SRA

  localparam int ALU_OP_W = 4;

  localparam logic [ALU_OP_W-1:0] ALU_ADD    = 4'd0;
  localparam logic [ALU_OP_W-1:0] ALU_SUB    = 4'd1;
  localparam logic [ALU_OP_W-1:0] ALU_SLL    = 4'd2;
  localparam logic [ALU_OP_W-1:0] ALU_SLT    = 4'd3;
  localparam logic [ALU_OP_W-1:0] ALU_SLTU   = 4'd4;
  localparam logic [ALU_OP_W-1:0] ALU_XOR    = 4'd5;
  localparam logic [ALU_OP_W-1:0] ALU_SRL    = 4'd6;
  localparam logic [ALU_OP_W-1:0] ALU_SRA    = 4'd7;
  localparam logic [ALU_OP_W-1:0] ALU_OR     = 4'd8;
  localparam logic [ALU_OP_W-1:0] ALU_AND    = 4'd9;
  localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 4'd10; // LUI

  // Sequencer states
  localparam int ST_W = 2;

  localparam logic [ST_W-1:0] ST_IDLE = 2'd0;
  localparam logic [ST_W-1:0] ST_EXEC = 2'd1;
  localparam logic [ST_W-1:0] ST_ACK  = 2'd2;

  typedef struct packed {
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]           imm;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [19:0]           imm;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } u_fmt_t;

  // One instruction word, viewed by format
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    u_fmt_t u;
  } instr_word_t;

endpackage

`default_nettype wire

/* source/decode_if.sv */
`default_nettype none

interface decode_if;

  logic [rv_pkg::REG_ADDR_W-1:0] rs1;
  logic [rv_pkg::REG_ADDR_W-1:0] rs2;
  logic [rv_pkg::REG_ADDR_W-1:0] rd;
  logic [rv_pkg::XLEN-1:0]       imm;     // Sign-extended or upper immediate
  logic                          use_imm;
  logic [rv_pkg::ALU_OP_W-1:0]   alu_op;
  logic                          rd_wr;
  logic                          illegal;

  modport decoder (
    output rs1, rs2, rd, imm, use_imm, alu_op, rd_wr, illegal
  );

  modport sequencer (
    input rs1, rs2, rd, imm, use_imm, alu_op, rd_wr, illegal
  );

endinterface

`default_nettype wire

/* source/reg_file.sv */
`default_nettype none

module reg_file (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          wr_en,
  input  logic [rv_pkg::REG_ADDR_W-1:0] wr_addr,
  input  logic [rv_pkg::XLEN-1:0]       wr_data,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rd1_addr,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rd2_addr,
  input  logic [rv_pkg::REG_ADDR_W-1:0] dbg_addr,
  output logic [rv_pkg::XLEN-1:0]       rd1_data,
  output logic [rv_pkg::XLEN-1:0]       rd2_data,
  output logic [rv_pkg::XLEN-1:0]       dbg_data
);

  logic [rv_pkg::XLEN-1:0] regs [rv_pkg::NUM_REGS];
  logic                    wr_ok;

  assign wr_ok = wr_en && (wr_addr != '0); // x0 stays hardwired

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < rv_pkg::NUM_REGS; i++) begin
        regs[i] <= rv_pkg::REG_INIT;
      end
    end else if (wr_ok) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Combinational read ports
  assign rd1_data = regs[rd1_addr];
  assign rd2_data = regs[rd2_addr];
  assign dbg_data = regs[dbg_addr];

  // Also covers a write aimed at x0 in the previous cycle
  x0_zero: assert property (@(posedge clk) disable iff (rst)
    regs[0] == rv_pkg::REG_INIT);

endmodule

`default_nettype wire

/* source/instr_decoder.sv */
`default_nettype none

module instr_decoder (
  input  rv_pkg::instr_word_t instr,
  decode_if.decoder           dec
);

  logic alt;
  logic bad;

  always_comb begin
    dec.rs1     = instr.r.rs1;
    dec.rs2     = instr.r.rs2;
    dec.rd      = instr.r.rd;
    dec.imm     = {{(rv_pkg::XLEN-12){instr.i.imm[11]}}, instr.i.imm};
    dec.use_imm = 1'b0;
    dec.alu_op  = rv_pkg::ALU_ADD;
    alt         = 1'b0;
    bad         = 1'b0;

    case (instr.r.opcode)
      rv_pkg::OPC_OP: begin
        alt = (instr.r.funct7 == rv_pkg::F7_ALT);
        // Alternate funct7 only valid for SUB and SRA
        bad = !((instr.r.funct7 == rv_pkg::F7_BASE) ||
                (alt && (instr.r.funct3 == 3'b000 || instr.r.funct3 == 3'b101)));
        case (instr.r.funct3)
          3'b000:  dec.alu_op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
          3'b001:  dec.alu_op = rv_pkg::ALU_SLL;
          3'b010:  dec.alu_op = rv_pkg::ALU_SLT;
          3'b011:  dec.alu_op = rv_pkg::ALU_SLTU;
          3'b100:  dec.alu_op = rv_pkg::ALU_XOR;
          3'b101:  dec.alu_op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
          3'b110:  dec.alu_op = rv_pkg::ALU_OR;
          default: dec.alu_op = rv_pkg::ALU_AND;
        endcase
      end

      rv_pkg::OPC_OP_IMM: begin
        dec.use_imm = 1'b1;
        case (instr.i.funct3)
          3'b000: dec.alu_op = rv_pkg::ALU_ADD;
          3'b001: begin
            dec.alu_op = rv_pkg::ALU_SLL;
            bad        = (instr.i.imm[11:6] != 6'b000000); // funct6 must be zero
          end
          3'b010: dec.alu_op = rv_pkg::ALU_SLT;
          3'b011: dec.alu_op = rv_pkg::ALU_SLTU;
          3'b100: dec.alu_op = rv_pkg::ALU_XOR;
          3'b101: begin
            alt        = (instr.i.imm[11:6] == 6'b010000);
            dec.alu_op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            bad        = !alt && (instr.i.imm[11:6] != 6'b000000);
          end
          3'b110:  dec.alu_op = rv_pkg::ALU_OR;
          default: dec.alu_op = rv_pkg::ALU_AND;
        endcase
      end

      rv_pkg::OPC_LUI: begin
        dec.rs1     = '0;
        dec.imm     = {{(rv_pkg::XLEN-32){instr.u.imm[19]}}, instr.u.imm, 12'b0};
        dec.use_imm = 1'b1;
        dec.alu_op  = rv_pkg::ALU_PASS_B;
      end

      default: bad = 1'b1; // Unsupported opcode
    endcase

    dec.illegal = bad;
    dec.rd_wr   = !bad;
  end

endmodule

`default_nettype wire

/* source/int_alu.sv */
`default_nettype none

module int_alu (
  input  logic [rv_pkg::XLEN-1:0]     a,
  input  logic [rv_pkg::XLEN-1:0]     b,
  input  logic [rv_pkg::ALU_OP_W-1:0] op,
  output logic [rv_pkg::XLEN-1:0]     y
);

  logic [5:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign shamt = b[5:0]; // RV64 shift amount
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;

  always_comb begin
    case (op)
      rv_pkg::ALU_ADD:    y = a + b;
      rv_pkg::ALU_SUB:    y = a - b;
      rv_pkg::ALU_SLL:    y = a << shamt;
      rv_pkg::ALU_SLT:    y = {{(rv_pkg::XLEN-1){1'b0}}, lt_s};
      rv_pkg::ALU_SLTU:   y = {{(rv_pkg::XLEN-1){1'b0}}, lt_u};
      rv_pkg::ALU_XOR:    y = a ^ b;
      rv_pkg::ALU_SRL:    y = a >> shamt;
      rv_pkg::ALU_SRA:    y = $unsigned($signed(a) >>> shamt);
      rv_pkg::ALU_OR:     y = a | b;
      rv_pkg::ALU_AND:    y = a & b;
      rv_pkg::ALU_PASS_B: y = b;
      default:            y = '0;
    endcase
  end

endmodule

`default_nettype wire

/* source/issue_ctrl.sv */
`default_nettype none

module issue_ctrl (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    instr_req,
  input  logic [rv_pkg::ILEN-1:0] instr,
  input  logic [rv_pkg::XLEN-1:0] rs2_data,
  output logic                    instr_ack,
  output rv_pkg::instr_word_t     instr_q,
  output logic [rv_pkg::XLEN-1:0] alu_b,
  output logic                    wr_en,
  decode_if.sequencer             dec
);

  logic [rv_pkg::ST_W-1:0] state;
  logic [rv_pkg::ST_W-1:0] state_nxt;

  always_comb begin
    state_nxt = state;
    case (state)
      rv_pkg::ST_IDLE: begin
        if (instr_req) state_nxt = rv_pkg::ST_EXEC;
      end
      rv_pkg::ST_EXEC: state_nxt = rv_pkg::ST_ACK; // Single cycle
      rv_pkg::ST_ACK: begin
        if (!instr_req) state_nxt = rv_pkg::ST_IDLE;
      end
      default: state_nxt = rv_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= rv_pkg::ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Instruction held for decode through EXEC and ACK
  always_ff @(posedge clk) begin
    if (state == rv_pkg::ST_IDLE && instr_req) begin
      instr_q <= instr;
    end
  end

  assign instr_ack = (state == rv_pkg::ST_ACK);
  assign alu_b     = dec.use_imm ? dec.imm : rs2_data;

  assign wr_en = (state == rv_pkg::ST_EXEC) && dec.rd_wr && !dec.illegal &&
                 (dec.rd != '0);

  ack_needs_req: assert property (@(posedge clk) disable iff (rst)
    $rose(instr_ack) |-> instr_req);

  // One write per transaction, even under a held request
  wr_single_exec: assert property (@(posedge clk) disable iff (rst)
    wr_en |-> $past(state == rv_pkg::ST_IDLE && instr_req));

endmodule

`default_nettype wire

/* source/exec_core.sv */
`default_nettype none

module exec_core (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          instr_req,
  input  logic [rv_pkg::ILEN-1:0]       instr,
  input  logic [rv_pkg::REG_ADDR_W-1:0] dbg_addr,
  output logic                          instr_ack,
  output logic                          illegal,
  output logic [rv_pkg::XLEN-1:0]       dbg_data
);

  rv_pkg::instr_word_t     instr_q;
  logic [rv_pkg::XLEN-1:0] rs1_data;
  logic [rv_pkg::XLEN-1:0] rs2_data;
  logic [rv_pkg::XLEN-1:0] alu_b;
  logic [rv_pkg::XLEN-1:0] alu_y;
  logic                    wr_en;

  decode_if dec_bus ();

  instr_decoder u_decoder (
    .instr (instr_q),
    .dec   (dec_bus.decoder)
  );

  issue_ctrl u_issue (
    .clk       (clk),
    .rst       (rst),
    .instr_req (instr_req),
    .instr     (instr),
    .rs2_data  (rs2_data),
    .instr_ack (instr_ack),
    .instr_q   (instr_q),
    .alu_b     (alu_b),
    .wr_en     (wr_en),
    .dec       (dec_bus.sequencer)
  );

  reg_file u_regs (
    .clk      (clk),
    .rst      (rst),
    .wr_en    (wr_en),
    .wr_addr  (dec_bus.rd),
    .wr_data  (alu_y),      // ALU result written back
    .rd1_addr (dec_bus.rs1),
    .rd2_addr (dec_bus.rs2),
    .dbg_addr (dbg_addr),
    .rd1_data (rs1_data),
    .rd2_data (rs2_data),
    .dbg_data (dbg_data)
  );

  int_alu u_alu (
    .a  (rs1_data),
    .b  (alu_b),
    .op (dec_bus.alu_op),
    .y  (alu_y)
  );

  assign illegal = dec_bus.illegal; // Stable while ack is high

endmodule

`default_nettype wire

/* testbench/clock_gen.sv */
`default_nettype none

module clock_gen (
  output logic clk
);

  // Period of 10
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

endmodule

`default_nettype wire

/* testbench/tb_exec_core.sv */
`default_nettype none

module tb_exec_core;

  localparam int RST_CYCLES  = 16;
  localparam int N_LUI       = 20;  // LUI and ADDI pairs
  localparam int N_ALU       = 100;
  localparam int N_X0        = 8;
  localparam int N_ILL       = 12;
  localparam int N_HOLD      = 3;
  localparam int HOLD_LONG   = 20;
  localparam int TXN_MAX     = 12;  // Worst case per transaction with short hold
  localparam int N_TXN       = 2 * N_LUI + N_ALU + N_X0 + N_ILL + N_HOLD;
  localparam int N_SWEEP     = 3;
  localparam int CYCLE_LIMIT = RST_CYCLES + N_TXN * TXN_MAX + N_HOLD * HOLD_LONG +
                               N_SWEEP * 34 + 100;

  logic        clk;
  logic        rst;
  logic        instr_req;
  logic [31:0] instr;
  logic [4:0]  dbg_addr;
  logic        instr_ack;
  logic        illegal;
  logic [63:0] dbg_data;

  logic [63:0] model [32];  // Architectural register model
  logic [63:0] exp_val;
  logic        exp_illegal;
  logic        sweep_en;
  logic [15:0] lfsr;
  logic        rst_q = 1'b1;
  logic        req_q;
  logic        ack_q;
  int          wait_cycles;
  int          cycles;
  string       test_name;

  clock_gen u_clk (
    .clk (clk)
  );

  exec_core UUT (
    .clk       (clk),
    .rst       (rst),
    .instr_req (instr_req),
    .instr     (instr),
    .dbg_addr  (dbg_addr),
    .instr_ack (instr_ack),
    .illegal   (illegal),
    .dbg_data  (dbg_data)
  );

  task automatic stop_failed();
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
    stop_failed();
  endtask

  // Cycles spent with the request up and no acknowledge yet
  always @(posedge clk) begin
    rst_q <= rst;
    req_q <= instr_req;
    ack_q <= instr_ack;
    if (!instr_req) begin
      wait_cycles <= 0;
    end else if (!instr_ack) begin
      wait_cycles <= wait_cycles + 1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: run not finished after %0d cycles in test %s", CYCLE_LIMIT, test_name);
      stop_failed();
    end
  end

  ack_after_reset: assert property (@(posedge clk) (rst_q && !rst) |-> !instr_ack)
    else report_mismatch("ack after reset", 64'd0, 64'($sampled(instr_ack)));

  ack_latency: assert property (@(posedge clk) disable iff (rst)
    (instr_ack && !ack_q) |-> wait_cycles == 2)
    else report_mismatch("ack latency", 64'd2, 64'($sampled(wait_cycles)));

  // Ack follows the request one cycle late once it is up
  ack_release: assert property (@(posedge clk) disable iff (rst)
    ack_q |-> instr_ack == req_q)
    else report_mismatch("ack release", 64'($sampled(req_q)), 64'($sampled(instr_ack)));

  reg_value: assert property (@(posedge clk) disable iff (rst)
    (instr_ack || sweep_en) |-> dbg_data == exp_val)
    else report_mismatch("register value", $sampled(exp_val), $sampled(dbg_data));

  illegal_flag: assert property (@(posedge clk) disable iff (rst)
    instr_ack |-> illegal == exp_illegal)
    else report_mismatch("illegal flag", 64'($sampled(exp_illegal)), 64'($sampled(illegal)));

  // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[62:0], fb};
    end
    return v;
  endfunction

  // ISA result and legality from the instruction fields
  task automatic predict(input logic [31:0] w, output logic bad, output logic [63:0] res);
    logic [63:0] a;
    logic [63:0] b;
    logic [5:0]  sh;
    logic        is_op;
    a     = model[w[19:15]];
    is_op = (w[6:0] == rv_pkg::OPC_OP);
    b     = is_op ? model[w[24:20]] : {{52{w[31]}}, w[31:20]};
    sh    = b[5:0];
    bad   = 1'b0;
    res   = '0;
    case (w[6:0])
      rv_pkg::OPC_LUI: res = {{32{w[31]}}, w[31:12], 12'h000};
      rv_pkg::OPC_OP: begin
        bad = (w[31:25] != 7'b0000000) &&
              !(w[31:25] == 7'b0100000 && (w[14:12] == 3'b000 || w[14:12] == 3'b101));
      end
      rv_pkg::OPC_OP_IMM: begin
        if (w[14:12] == 3'b001) bad = (w[31:26] != 6'b000000);
        if (w[14:12] == 3'b101) bad = (w[31:26] != 6'b000000) && (w[31:26] != 6'b010000);
      end
      default: bad = 1'b1;
    endcase
    if (is_op || w[6:0] == rv_pkg::OPC_OP_IMM) begin
      case (w[14:12])
        3'b000: res = (is_op && w[30]) ? a - b : a + b;
        3'b001: res = a << sh;
        3'b010: res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        3'b011: res = (a < b) ? 64'd1 : 64'd0;
        3'b100: res = a ^ b;
        3'b101: begin
          if (w[30]) res = $signed(a) >>> sh;
          else res = a >> sh;
        end
        3'b110: res = a | b;
        default: res = a & b;
      endcase
    end
  endtask

  function automatic logic [31:0] gen_alu();
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic        alt;
    logic [11:0] imm;
    f3  = 3'(take_bits(3));
    rd  = 5'(take_bits(5));
    rs1 = 5'(take_bits(5));
    alt = 1'(take_bits(1));
    if (take_bits(1) == 64'd0) begin
      // R-type, alternate funct7 only for SUB and SRA
      alt = alt && (f3 == 3'b000 || f3 == 3'b101);
      return {1'b0, alt, 5'b00000, 5'(take_bits(5)), rs1, f3, rd, rv_pkg::OPC_OP};
    end
    imm = 12'(take_bits(12));
    if (f3 == 3'b001) imm[11:6] = 6'b000000;
    if (f3 == 3'b101) imm[11:6] = alt ? 6'b010000 : 6'b000000;
    return {imm, rs1, f3, rd, rv_pkg::OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] gen_illegal();
    logic [1:0]  kind;
    logic [31:0] w;
    logic [2:0]  f3;
    kind = 2'(take_bits(2));
    w    = 32'(take_bits(32));
    f3   = w[14:12];
    case (kind)
      2'd0: begin
        // Move a kept opcode off to a neighbour
        if (w[6:0] inside {rv_pkg::OPC_OP, rv_pkg::OPC_OP_IMM, rv_pkg::OPC_LUI}) begin
          w[3] = ~w[3];
        end
      end
      2'd1: w = {w[31:26], 1'b1, w[24:7], rv_pkg::OPC_OP};
      2'd2: w = {w[31:27], 1'b1, w[25:15], w[14], 2'b01, w[11:7], rv_pkg::OPC_OP_IMM};
      default: begin
        if (f3 == 3'b000 || f3 == 3'b101) f3 = f3 ^ 3'b001;
        w = {7'b0100000, w[24:15], f3, w[11:7], rv_pkg::OPC_OP};
      end
    endcase
    return w;
  endfunction

  // One four-phase transaction, request held for hold cycles after ack
  task automatic run_instr(input logic [31:0] w, input int hold);
    logic        bad;
    logic [63:0] res;
    logic [4:0]  rd;
    rd = w[11:7];
    predict(w, bad, res);
    if (!bad && rd != 5'd0) model[rd] = res;
    @(posedge clk);
    instr       <= w;
    instr_req   <= 1'b1;
    dbg_addr    <= rd;
    exp_val     <= model[rd];
    exp_illegal <= bad;
    do begin
      @(posedge clk);
    end while (!instr_ack);
    repeat (hold) @(posedge clk);
    instr_req <= 1'b0;
    do begin
      @(posedge clk);
    end while (instr_ack);
  endtask

  task automatic sweep_regs();
    for (int a = 0; a < 32; a++) begin
      @(posedge clk);
      sweep_en <= 1'b1;
      dbg_addr <= 5'(a);
      exp_val  <= model[a];
    end
    @(posedge clk);
    sweep_en <= 1'b0;
  endtask

  initial begin
    logic [4:0]  rd;
    logic [31:0] w;
    rst         = 1'b1;
    instr_req   = 1'b0;
    instr       = '0;
    dbg_addr    = '0;
    exp_val     = '0;
    exp_illegal = 1'b0;
    sweep_en    = 1'b0;
    lfsr        = 16'd21086;
    cycles      = 0;
    wait_cycles = 0;
    test_name   = "reset";
    for (int i = 0; i < 32; i++) begin
      model[i] = '0;
    end
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    sweep_regs();

    test_name = "lui_addi";
    for (int n = 0; n < N_LUI; n++) begin
      rd = 5'(take_bits(5));
      if (rd == 5'd0) rd = 5'd31;
      w = {20'(take_bits(20)), rd, rv_pkg::OPC_LUI};
      run_instr(w, int'(take_bits(2)));
      w = {12'(take_bits(12)), rd, 3'b000, rd, rv_pkg::OPC_OP_IMM};
      run_instr(w, int'(take_bits(2)));
    end

    test_name = "alu_random";
    for (int n = 0; n < N_ALU; n++) begin
      w = gen_alu();
      run_instr(w, int'(take_bits(2)));
    end

    test_name = "rd_x0";
    for (int n = 0; n < N_X0; n++) begin
      w        = gen_alu();
      w[11:7]  = 5'd0;
      run_instr(w, int'(take_bits(2)));
    end

    test_name = "illegal";
    for (int n = 0; n < N_ILL; n++) begin
      w = gen_illegal();
      run_instr(w, int'(take_bits(2)));
    end
    sweep_regs();

    test_name = "hold_req";
    for (int n = 0; n < N_HOLD; n++) begin
      run_instr({12'd1, 5'd1, 3'b000, 5'd1, rv_pkg::OPC_OP_IMM}, HOLD_LONG); // addi x1, x1, 1
    end
    test_name = "final";
    sweep_regs();

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
source/rv_pkg.sv
source/decode_if.sv
source/reg_file.sv
source/instr_decoder.sv
source/int_alu.sv
source/issue_ctrl.sv
source/exec_core.sv
testbench/clock_gen.sv
testbench/tb_exec_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the exec_core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module tb_exec_core -f filelist.f -o sim_exec_core

./obj_dir/sim_exec_core | tee sim.log

if grep -q "Result: FAILED" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
echo "Simulation passed"
